/* rtl/bpu_consts.svh */
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

`define XLEN       32
`define HIST_LEN   16

// gshare table, pc[9:2] xor history[7:0]
`define DIR_IDX_W  8
`define BTB_IDX_W  8
`define BTB_TAG_W  14
`define RAS_DEPTH  8

`define OP_BRANCH  7'b1100011
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define REG_RA     5'd1

// weakly not taken
`define CTR_INIT   2'b01

`endif

/* rtl/bpu_pkg.sv */
`include "bpu_consts.svh"

package bpu_pkg;

    typedef logic [`XLEN-1:0] xaddr_t;
    typedef logic [`HIST_LEN-1:0] hist_t;

    // upper bit set means taken
    typedef logic [1:0] ctr_t;

    typedef struct packed {
        logic                  valid;
        logic [`BTB_TAG_W-1:0] tag;
        xaddr_t                target;
    } btb_entry_t;

    typedef struct packed {
        logic   is_branch;
        logic   is_jal;
        logic   is_jalr;
        logic   is_call;
        logic   is_ret;
        xaddr_t br_off;
        xaddr_t jal_off;
    } inst_class_t;

endpackage

/* rtl/inst_decode.sv */
`timescale 1ns/1ps
`include "bpu_consts.svh"

module inst_decode (
    input  logic [`XLEN-1:0]     inst_i,
    output bpu_pkg::inst_class_t cls_o
);
    import bpu_pkg::*;

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       is_jal;
    logic       is_jalr;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    assign is_jal  = (opcode == `OP_JAL);
    assign is_jalr = (opcode == `OP_JALR);

    assign cls_o.is_branch = (opcode == `OP_BRANCH);
    assign cls_o.is_jal    = is_jal;
    assign cls_o.is_jalr   = is_jalr;
    // jalr x0, 0(ra)
    assign cls_o.is_ret    = is_jalr && (rd == 5'd0) && (rs1 == `REG_RA);
    assign cls_o.is_call   = is_jal || (is_jalr && (rd != 5'd0));

    // b-type immediate
    assign cls_o.br_off = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                           inst_i[11:8], 1'b0};

    // j-type immediate
    assign cls_o.jal_off = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                            inst_i[30:21], 1'b0};

endmodule

/* rtl/pred_table.sv */
`timescale 1ns/1ps

module pred_table #(
    parameter type    entry_t     = logic [1:0],
    parameter int     DEPTH       = 256,
    parameter entry_t RESET_ENTRY = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    input  logic [$clog2(DEPTH)-1:0] rd2_idx_i,
    output entry_t                   rd2_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    assign rd_data_o  = mem[rd_idx_i];
    assign rd2_data_o = mem[rd2_idx_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_ENTRY;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

/* rtl/btb.sv */
`timescale 1ns/1ps
`include "bpu_consts.svh"

module btb (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::xaddr_t      lookup_pc_i,
    output logic                 hit_o,
    output bpu_pkg::xaddr_t      target_o,
    input  logic                 upd_en_i,
    input  bpu_pkg::xaddr_t      upd_pc_i,
    input  bpu_pkg::inst_class_t upd_cls_i,
    input  logic                 upd_taken_i,
    input  bpu_pkg::xaddr_t      upd_target_i
);
    import bpu_pkg::*;

    logic [`BTB_IDX_W-1:0] lookup_idx;
    logic [`BTB_TAG_W-1:0] lookup_tag;
    logic [`BTB_IDX_W-1:0] upd_idx;
    btb_entry_t            lookup_entry;
    btb_entry_t            upd_old_entry;
    btb_entry_t            upd_new_entry;
    logic                  alloc;

    assign lookup_idx = lookup_pc_i[`BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[`XLEN-1:`XLEN-`BTB_TAG_W];
    assign upd_idx    = upd_pc_i[`BTB_IDX_W+1:2];

    assign upd_new_entry.valid  = 1'b1;
    assign upd_new_entry.tag    = upd_pc_i[`XLEN-1:`XLEN-`BTB_TAG_W];
    assign upd_new_entry.target = upd_target_i;

    // skip the write when the entry already holds the same mapping
    assign alloc = upd_en_i && upd_taken_i && (upd_old_entry != upd_new_entry) &&
                   (upd_cls_i.is_branch || upd_cls_i.is_jal || upd_cls_i.is_jalr);

    pred_table #(
        .entry_t     (btb_entry_t),
        .DEPTH       (1 << `BTB_IDX_W),
        .RESET_ENTRY ('0)
    ) u_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (lookup_idx),
        .rd_data_o  (lookup_entry),
        .rd2_idx_i  (upd_idx),
        .rd2_data_o (upd_old_entry),
        .wr_en_i    (alloc),
        .wr_idx_i   (upd_idx),
        .wr_data_i  (upd_new_entry)
    );

    assign hit_o    = lookup_entry.valid && (lookup_entry.tag == lookup_tag);
    assign target_o = lookup_entry.target;

endmodule

/* rtl/dir_predictor.sv */
`timescale 1ns/1ps
`include "bpu_consts.svh"

module dir_predictor (
    input  logic            clk,
    input  logic            rst,
    input  bpu_pkg::xaddr_t pc_i,
    output logic            taken_o,
    output bpu_pkg::hist_t  history_o,
    input  logic            flush_i,
    input  bpu_pkg::hist_t  flush_hist_i,
    input  logic            upd_en_i,
    input  bpu_pkg::xaddr_t upd_pc_i,
    input  bpu_pkg::hist_t  upd_hist_i,
    input  logic            upd_is_branch_i,
    input  logic            upd_taken_i
);
    import bpu_pkg::*;

    hist_t                 history_q;
    logic [`DIR_IDX_W-1:0] rd_idx;
    logic [`DIR_IDX_W-1:0] upd_idx;
    ctr_t                  rd_ctr;
    ctr_t                  upd_ctr;
    ctr_t                  upd_ctr_next;

    // a flush redirect wins over a same-cycle resolution
    always_ff @(posedge clk) begin
        if (rst) begin
            history_q <= '0;
        end else if (flush_i) begin
            history_q <= flush_hist_i;
        end else if (upd_en_i) begin
            history_q <= {history_q[`HIST_LEN-2:0], upd_taken_i};
        end
    end

    assign history_o = history_q;

    // gshare hash
    assign rd_idx  = pc_i[`DIR_IDX_W+1:2] ^ history_q[`DIR_IDX_W-1:0];
    assign upd_idx = upd_pc_i[`DIR_IDX_W+1:2] ^ upd_hist_i[`DIR_IDX_W-1:0];

    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd_taken_i && (upd_ctr != 2'b11)) begin
            upd_ctr_next = ctr_t'(upd_ctr + 2'd1);
        end else if (!upd_taken_i && (upd_ctr != 2'b00)) begin
            upd_ctr_next = ctr_t'(upd_ctr - 2'd1);
        end
    end

    pred_table #(
        .entry_t     (ctr_t),
        .DEPTH       (1 << `DIR_IDX_W),
        .RESET_ENTRY (`CTR_INIT)
    ) u_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (rd_idx),
        .rd_data_o  (rd_ctr),
        .rd2_idx_i  (upd_idx),
        .rd2_data_o (upd_ctr),
        .wr_en_i    (upd_en_i && upd_is_branch_i),
        .wr_idx_i   (upd_idx),
        .wr_data_i  (upd_ctr_next)
    );

    assign taken_o = rd_ctr[1];

endmodule

/* rtl/return_stack.sv */
`timescale 1ns/1ps
`include "bpu_consts.svh"

module return_stack #(
    parameter int DEPTH = `RAS_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 top_valid_o,
    output bpu_pkg::xaddr_t      top_o,
    input  logic                 upd_en_i,
    input  bpu_pkg::xaddr_t      upd_pc_i,
    input  bpu_pkg::inst_class_t upd_cls_i
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    xaddr_t         stack [DEPTH];
    // count of valid entries, one extra bit to reach DEPTH
    logic [PTR_W:0] ptr_q;
    logic [PTR_W:0] top_ptr;
    xaddr_t         ret_addr;

    assign ret_addr = upd_pc_i + xaddr_t'(4);
    assign top_ptr  = ptr_q - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (upd_en_i && upd_cls_i.is_call) begin
            if (ptr_q == (PTR_W + 1)'(DEPTH)) begin
                // full, wrap onto the bottom slot
                ptr_q <= (PTR_W + 1)'(1);
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end else if (upd_en_i && upd_cls_i.is_ret && (ptr_q != '0)) begin
            ptr_q <= top_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en_i && upd_cls_i.is_call) begin
            if (ptr_q == (PTR_W + 1)'(DEPTH)) begin
                stack[0] <= ret_addr;
            end else begin
                stack[ptr_q[PTR_W-1:0]] <= ret_addr;
            end
        end
    end

    assign top_valid_o = (ptr_q != '0);
    assign top_o       = stack[top_ptr[PTR_W-1:0]];

endmodule

/* rtl/bpu_top.sv */
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            if_stall_i,
    input  logic            flush_i,
    input  bpu_pkg::xaddr_t if_pc_i,
    input  bpu_pkg::xaddr_t if_inst_i,
    input  logic            ex_branch_valid_i,
    input  logic            ex_branch_taken_i,
    input  bpu_pkg::xaddr_t ex_pc_i,
    input  bpu_pkg::xaddr_t ex_inst_i,
    input  bpu_pkg::xaddr_t ex_target_i,
    input  bpu_pkg::hist_t  ex_history_i,
    output logic            branch_or_not_o,
    output logic            pdt_res_o,
    output bpu_pkg::xaddr_t pdt_pc_o,
    output bpu_pkg::hist_t  history_o
);
    import bpu_pkg::*;

    inst_class_t if_cls;
    inst_class_t ex_cls;
    logic        upd_en;
    logic        btb_hit;
    xaddr_t      btb_target;
    logic        dir_taken;
    logic        ras_valid;
    xaddr_t      ras_top;
    xaddr_t      pc_plus4;

    assign upd_en   = ex_branch_valid_i && !if_stall_i && !flush_i;
    assign pc_plus4 = if_pc_i + xaddr_t'(4);

    inst_decode u_if_dec (.inst_i(if_inst_i), .cls_o(if_cls));
    inst_decode u_ex_dec (.inst_i(ex_inst_i), .cls_o(ex_cls));

    btb u_btb (
        .clk (clk), .rst (rst),
        .lookup_pc_i  (if_pc_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_en_i     (upd_en),
        .upd_pc_i     (ex_pc_i),
        .upd_cls_i    (ex_cls),
        .upd_taken_i  (ex_branch_taken_i),
        .upd_target_i (ex_target_i)
    );

    dir_predictor u_dir (
        .clk (clk), .rst (rst),
        .pc_i            (if_pc_i),
        .taken_o         (dir_taken),
        .history_o       (history_o),
        .flush_i         (flush_i),
        .flush_hist_i    (ex_history_i),
        .upd_en_i        (upd_en),
        .upd_pc_i        (ex_pc_i),
        .upd_hist_i      (ex_history_i),
        .upd_is_branch_i (ex_cls.is_branch),
        .upd_taken_i     (ex_branch_taken_i)
    );

    return_stack #(.DEPTH(`RAS_DEPTH)) u_ras (
        .clk (clk), .rst (rst),
        .top_valid_o (ras_valid),
        .top_o       (ras_top),
        .upd_en_i    (upd_en),
        .upd_pc_i    (ex_pc_i),
        .upd_cls_i   (ex_cls)
    );

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;
        if (!flush_i && (if_cls.is_branch || if_cls.is_jal || if_cls.is_jalr)) begin
            branch_or_not_o = 1'b1;
            if (if_cls.is_ret) begin
                pdt_res_o = 1'b1;
                if (ras_valid) begin
                    pdt_pc_o = ras_top;
                end else if (btb_hit) begin
                    pdt_pc_o = btb_target;
                end
            end else if (if_cls.is_jalr) begin
                pdt_res_o = btb_hit;
                if (btb_hit) begin
                    pdt_pc_o = btb_target;
                end
            end else if (if_cls.is_jal) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = if_pc_i + if_cls.jal_off;
            end else begin
                // conditional branch, btb target preferred over the offset
                pdt_res_o = dir_taken;
                if (dir_taken) begin
                    pdt_pc_o = btb_hit ? btb_target : if_pc_i + if_cls.br_off;
                end
            end
        end
    end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // held for four rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

/* testbench/bpu_sva.sv */
`timescale 1ns/1ps

module bpu_sva (
    input logic           clk,
    input logic           rst,
    input logic           flush_i,
    input logic           branch_or_not_i,
    input logic           pdt_res_i,
    input bpu_pkg::hist_t history_i
);

    // no prediction while fetch is being redirected
    flush_no_pred: assert property (@(posedge clk) disable iff (rst)
        flush_i |-> !branch_or_not_i)
        else $error("branch_or_not_o high during flush");

    taken_is_branch: assert property (@(posedge clk) disable iff (rst)
        pdt_res_i |-> branch_or_not_i)
        else $error("pdt_res_o high without branch_or_not_o");

    hist_cleared: assert property (@(posedge clk)
        $fell(rst) |-> (history_i == '0))
        else $error("history_o not cleared by reset");

endmodule

bind bpu_top bpu_sva u_sva (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .branch_or_not_i (branch_or_not_o),
    .pdt_res_i       (pdt_res_o),
    .history_i       (history_o)
);

/* testbench/tb_bpu.sv */
`timescale 1ns/1ps
`include "bpu_consts.svh"

module tb_bpu;
    import bpu_pkg::*;

    localparam xaddr_t INST_ALU = 32'h0010_0093;

    logic   clk;
    logic   rst;
    logic   if_stall_i;
    logic   flush_i;
    xaddr_t if_pc_i;
    xaddr_t if_inst_i;
    logic   ex_branch_valid_i;
    logic   ex_branch_taken_i;
    xaddr_t ex_pc_i;
    xaddr_t ex_inst_i;
    xaddr_t ex_target_i;
    hist_t  ex_history_i;
    logic   branch_or_not_o;
    logic   pdt_res_o;
    xaddr_t pdt_pc_o;
    hist_t  history_o;

    integer seed = 32'hedb1_b6a0;
    int     errors;
    int     checks;
    int     tests;
    int     err_base;
    hist_t  exp_hist;
    logic   rst_ok;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    bpu_top uut (
        .clk               (clk),
        .rst               (rst),
        .if_stall_i        (if_stall_i),
        .flush_i           (flush_i),
        .if_pc_i           (if_pc_i),
        .if_inst_i         (if_inst_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_inst_i         (ex_inst_i),
        .ex_target_i       (ex_target_i),
        .ex_history_i      (ex_history_i),
        .branch_or_not_o   (branch_or_not_o),
        .pdt_res_o         (pdt_res_o),
        .pdt_pc_o          (pdt_pc_o),
        .history_o         (history_o)
    );

    // beq x0, x0, off
    function automatic xaddr_t enc_branch(input logic [12:0] off);
        enc_branch = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic xaddr_t enc_jal(input logic [4:0] rd, input logic [20:0] off);
        enc_jal = {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic xaddr_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        enc_jalr = {12'd0, rs1, 3'b000, rd, `OP_JALR};
    endfunction

    // 2-bit saturating counter
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_step = ctr;
        if (taken && ctr != 2'b11) ctr_step = ctr + 2'd1;
        if (!taken && ctr != 2'b00) ctr_step = ctr - 2'd1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input xaddr_t got, input xaddr_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_fetch(input xaddr_t pc, input xaddr_t inst, input logic exp_br,
                               input logic exp_res, input xaddr_t exp_pc);
        if_pc_i   = pc;
        if_inst_i = inst;
        #20;
        check_value("branch_or_not_o", branch_or_not_o, exp_br);
        check_value("pdt_res_o", pdt_res_o, exp_res);
        check_value("pdt_pc_o", pdt_pc_o, exp_pc);
        check_value("history_o", history_o, exp_hist);
        next_cycle();
    endtask

    // one-cycle resolution pulse from execute
    task automatic resolve(input xaddr_t pc, input xaddr_t inst, input xaddr_t target,
                           input logic taken, input hist_t hist);
        ex_pc_i           = pc;
        ex_inst_i         = inst;
        ex_target_i       = target;
        ex_branch_taken_i = taken;
        ex_history_i      = hist;
        ex_branch_valid_i = 1'b1;
        if (!if_stall_i && !flush_i) exp_hist = {exp_hist[`HIST_LEN-2:0], taken};
        next_cycle();
        ex_branch_valid_i = 1'b0;
    endtask

    task automatic flush_to(input hist_t hist);
        flush_i      = 1'b1;
        ex_history_i = hist;
        exp_hist     = hist;
        next_cycle();
        flush_i = 1'b0;
    endtask

    task automatic begin_test();
        err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_base) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - err_base);
    endtask

    task automatic wait_reset(output logic ok);
        int n;
        n = 0;
        @(posedge clk);
        while (rst && n < 20) begin
            @(posedge clk);
            n++;
        end
        ok = !rst;
        #10;
    endtask

    task automatic after_reset_check();
        xaddr_t pc;
        begin_test();
        pc = xaddr_t'($random(seed)) & 32'hffff_fffc;
        check_fetch(pc, INST_ALU, 1'b0, 1'b0, pc + 4);
        pc = xaddr_t'($random(seed)) & 32'hffff_fffc;
        check_fetch(pc, enc_branch(13'd64), 1'b1, 1'b0, pc + 4);
        end_test("after reset");
    endtask

    task automatic jal_targets();
        xaddr_t      pc;
        logic [20:0] off;
        begin_test();
        for (int i = 0; i < 8; i++) begin
            pc  = xaddr_t'($random(seed)) & 32'hffff_fffc;
            off = 21'($random(seed)) & 21'h1f_fffe;
            // even passes jump forward, odd passes backward
            off[20] = i[0];
            check_fetch(pc, enc_jal(5'd0, off), 1'b1, 1'b1, pc + {{11{off[20]}}, off});
        end
        end_test("jal");
    endtask

    task automatic branch_training();
        xaddr_t pc;
        xaddr_t inst;
        xaddr_t target;
        ctr_t   ctr;
        begin_test();
        pc   = xaddr_t'($random(seed)) & 32'hffff_fffc;
        inst = enc_branch(13'd64);
        // differs from pc + offset so the btb path is visible
        target = pc + 32'h100;
        ctr    = `CTR_INIT;
        repeat (2) begin
            resolve(pc, inst, target, 1'b1, '0);
            ctr = ctr_step(ctr, 1'b1);
        end
        flush_to('0);
        check_fetch(pc, inst, 1'b1, ctr[1], ctr[1] ? target : pc + 4);
        repeat (2) begin
            resolve(pc, inst, target, 1'b0, '0);
            ctr = ctr_step(ctr, 1'b0);
        end
        flush_to('0);
        check_fetch(pc, inst, 1'b1, ctr[1], ctr[1] ? target : pc + 4);
        end_test("branch training");
    endtask

    task automatic history_tracking();
        logic taken;
        begin_test();
        for (int i = 0; i < 6; i++) begin
            taken = 1'($random(seed));
            resolve(32'h0000_4000 + i * 4, enc_branch(13'd16), 32'h0000_4010 + i * 4,
                    taken, exp_hist);
            check_value("history_o", history_o, exp_hist);
        end
        // stalled resolution leaves history alone
        if_stall_i = 1'b1;
        resolve(32'h0000_4100, enc_branch(13'd16), 32'h0000_4110, 1'b1, exp_hist);
        check_value("history_o", history_o, exp_hist);
        if_stall_i = 1'b0;
        flush_to(hist_t'($random(seed)));
        check_value("history_o", history_o, exp_hist);
        end_test("history");
    endtask

    task automatic return_stack_order();
        xaddr_t ret_inst;
        xaddr_t call_inst;
        begin_test();
        ret_inst  = enc_jalr(5'd0, `REG_RA);
        call_inst = enc_jal(`REG_RA, 21'h100);
        resolve(32'h8000_1000, call_inst, 32'h8000_1100, 1'b1, exp_hist);
        check_fetch(32'h8000_2000, ret_inst, 1'b1, 1'b1, 32'h8000_1004);
        resolve(32'h8000_2000, ret_inst, 32'h8000_1004, 1'b1, exp_hist);
        // nested calls
        resolve(32'h8000_3000, call_inst, 32'h8000_3100, 1'b1, exp_hist);
        resolve(32'h8000_3100, call_inst, 32'h8000_3200, 1'b1, exp_hist);
        check_fetch(32'h8000_2000, ret_inst, 1'b1, 1'b1, 32'h8000_3104);
        resolve(32'h8000_2000, ret_inst, 32'h8000_3104, 1'b1, exp_hist);
        check_fetch(32'h8000_2000, ret_inst, 1'b1, 1'b1, 32'h8000_3004);
        resolve(32'h8000_2000, ret_inst, 32'h8000_3004, 1'b1, exp_hist);
        // stack now empty and this pc has no btb entry
        check_fetch(32'h8000_5010, ret_inst, 1'b1, 1'b1, 32'h8000_5014);
        end_test("return stack");
    endtask

    task automatic jalr_targets();
        xaddr_t inst;
        begin_test();
        inst = enc_jalr(5'd0, 5'd6);
        check_fetch(32'h8000_6020, inst, 1'b1, 1'b0, 32'h8000_6024);
        // a stalled resolution must not allocate
        if_stall_i = 1'b1;
        resolve(32'h8000_6020, inst, 32'h8000_7a00, 1'b1, exp_hist);
        if_stall_i = 1'b0;
        check_fetch(32'h8000_6020, inst, 1'b1, 1'b0, 32'h8000_6024);
        resolve(32'h8000_6020, inst, 32'h8000_7a00, 1'b1, exp_hist);
        check_fetch(32'h8000_6020, inst, 1'b1, 1'b1, 32'h8000_7a00);
        end_test("jalr");
    endtask

    initial begin
        if_stall_i        = 1'b0;
        flush_i           = 1'b0;
        if_pc_i           = '0;
        if_inst_i         = INST_ALU;
        ex_branch_valid_i = 1'b0;
        ex_branch_taken_i = 1'b0;
        ex_pc_i           = '0;
        ex_inst_i         = INST_ALU;
        ex_target_i       = '0;
        ex_history_i      = '0;
        exp_hist          = '0;
        errors            = 0;
        checks            = 0;
        tests             = 0;
        wait_reset(rst_ok);
        if (rst_ok) begin
            after_reset_check();
            jal_targets();
            branch_training();
            history_tracking();
            return_stack_order();
            jalr_targets();
        end else begin
            errors++;
            $display("reset was not released within 20 cycles");
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/bpu_pkg.sv
rtl/inst_decode.sv
rtl/pred_table.sv
rtl/btb.sv
rtl/dir_predictor.sv
rtl/return_stack.sv
rtl/bpu_top.sv
testbench/tb_clock_gen.sv
testbench/bpu_sva.sv
testbench/tb_bpu.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bpu_pkg.sv
      - rtl/inst_decode.sv
      - rtl/pred_table.sv
      - rtl/btb.sv
      - rtl/dir_predictor.sv
      - rtl/return_stack.sv
      - rtl/bpu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_clock_gen.sv
      - testbench/bpu_sva.sv
      - testbench/tb_bpu.sv
